// File: hdl/credit_counter.sv
`timescale 1ns/100ps
// ####################
// write-back credit counter
// ####################
module credit_counter import mips_pkg::*; #(
   parameter int WB_CREDITS = WB_CREDITS_DEF
) (
   input  logic clk,
   input  logic rst_b,
   input  logic spend,
   input  logic wb_credit,
   output logic has_credit
);

   localparam int CNT_W = $clog2(WB_CREDITS + 1);

   logic [CNT_W-1:0] count;

   // starts full, spend on issue, refill on receiver pulse
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         count <= CNT_W'(WB_CREDITS);
      end else begin
         case ({spend, wb_credit})
            2'b10:   count <= count - 1'b1;
            2'b01:   count <= count + 1'b1;
            default: ;
         endcase
      end
   end

   assign has_credit = (count != '0);

endmodule

// File: hdl/inst_decode.sv
`timescale 1ns/100ps
// ####################
// instruction decoder
// fields, immediate extension, alu select
// halt flags for SYSCALL and RI
// ####################
module inst_decode import mips_pkg::*; (
   input  word_t     inst,
   output dec_ctrl_t ctrl,
   output reg_idx_t  rs,
   output reg_idx_t  rt
);

   opcode_e  opcode;
   funct_e   funct;
   reg_idx_t rd;
   word_t    se_imm;
   word_t    ze_imm;

   assign opcode = opcode_e'(inst[31:26]);
   assign funct  = funct_e'(inst[5:0]);
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   // arithmetic immediates are signed, logical ones are not
   assign se_imm = {{16{inst[15]}}, inst[15:0]};
   assign ze_imm = {16'h0000, inst[15:0]};

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = ALU_ADD;
      ctrl.imm    = se_imm;
      // i-type writes rt
      ctrl.dest   = rt;
      ctrl.writes = 1'b1;
      case (opcode)
         OP_SPECIAL: begin
            ctrl.dest = rd;
            case (funct)
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               FN_SLLV: ctrl.alu_op = ALU_SLLV;
               FN_SRLV: ctrl.alu_op = ALU_SRLV;
               FN_SRAV: ctrl.alu_op = ALU_SRAV;
               FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SYSCALL: begin
                  ctrl.writes     = 1'b0;
                  ctrl.is_syscall = 1'b1;
               end
               default: begin
                  ctrl.writes = 1'b0;
                  ctrl.is_ri  = 1'b1;
               end
            endcase
         end
         OP_ADDIU: ctrl.use_imm = 1'b1;
         OP_SLTI: begin
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = ALU_SLT;
         end
         OP_ANDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.imm     = ze_imm;
            ctrl.alu_op  = ALU_AND;
         end
         OP_ORI: begin
            ctrl.use_imm = 1'b1;
            ctrl.imm     = ze_imm;
            ctrl.alu_op  = ALU_OR;
         end
         OP_XORI: begin
            ctrl.use_imm = 1'b1;
            ctrl.imm     = ze_imm;
            ctrl.alu_op  = ALU_XOR;
         end
         OP_LUI: begin
            ctrl.use_imm = 1'b1;
            ctrl.imm     = ze_imm;
            ctrl.alu_op  = ALU_LUI;
         end
         // anything else is a reserved instruction
         default: begin
            ctrl.writes = 1'b0;
            ctrl.is_ri  = 1'b1;
         end
      endcase
   end

endmodule

// File: hdl/inst_queue.sv
`timescale 1ns/100ps
// ####################
// instruction FIFO, circular buffer
// one input credit back per pop
// ####################
module inst_queue import mips_pkg::*; #(
   parameter int IQ_DEPTH = IQ_DEPTH_DEF
) (
   input  logic      clk,
   input  logic      rst_b,
   input  inst_pkt_t inst_in,
   input  logic      pop,
   output word_t     head,
   output logic      not_empty,
   output logic      inst_credit
);

   // keep pointers at least one bit wide for a depth of 1
   localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
   localparam int CNT_W = $clog2(IQ_DEPTH + 1);

   word_t            mem [IQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // wrap at depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(IQ_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // storage, the sender never overruns it
   always_ff @(posedge clk) begin
      if (inst_in.valid) begin
         mem[wr_ptr] <= inst_in.inst;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         inst_credit <= 1'b0;
      end else begin
         if (inst_in.valid) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         // push and pop together leave the count alone
         case ({inst_in.valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
         // slot freed, hand a credit back next cycle
         inst_credit <= pop;
      end
   end

   assign head      = mem[rd_ptr];
   assign not_empty = (count != '0);

endmodule

// File: hdl/issue_fsm.sv
`timescale 1ns/100ps
// ####################
// issue control FSM
// run until SYSCALL or RI
// ####################
module issue_fsm import mips_pkg::*; (
   input  logic        clk,
   input  logic        rst_b,
   input  logic        not_empty,
   input  logic        has_credit,
   input  dec_ctrl_t   ctrl,
   output logic        pop,
   output logic        issue_wb,
   output logic        halted,
   output halt_cause_e halt_cause
);

   core_state_e state;
   core_state_e state_nxt;
   logic        halt_now;

   // work in the queue and room downstream
   assign pop      = (state == ST_RUN) && not_empty && has_credit;
   assign halt_now = ctrl.is_syscall || ctrl.is_ri;
   // halting instructions are popped but never written back
   assign issue_wb = pop && ctrl.writes && !halt_now;
   assign halted   = (state == ST_HALTED);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_RUN: begin
            if (pop && halt_now) begin
               state_nxt = ST_HALTED;
            end
         end
         // only reset leaves halted
         default: state_nxt = ST_HALTED;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         state      <= ST_RUN;
         halt_cause <= HALT_NONE;
      end else begin
         state <= state_nxt;
         if (pop && halt_now) begin
            halt_cause <= ctrl.is_syscall ? HALT_SYSCALL : HALT_RI;
         end
      end
   end

endmodule

// File: hdl/mips_alu.sv
`timescale 1ns/100ps
// ####################
// integer alu
// add/sub, logic, slt, shifts, lui
// ####################
module mips_alu import mips_pkg::*; (
   input  alu_op_e    op,
   input  word_t      op_a,
   input  word_t      op_b,
   input  logic [4:0] shamt,
   output word_t      result
);

   // op_a carries rs, op_b carries rt or the immediate
   always_comb begin
      case (op)
         ALU_ADD:  result = op_a + op_b;
         ALU_SUB:  result = op_a - op_b;
         // fixed shifts act on rt by shamt
         ALU_SLL:  result = op_b << shamt;
         ALU_SRL:  result = op_b >> shamt;
         ALU_SRA:  result = $signed(op_b) >>> shamt;
         // variable shifts, amount from low bits of rs
         ALU_SLLV: result = op_b << op_a[4:0];
         ALU_SRLV: result = op_b >> op_a[4:0];
         ALU_SRAV: result = $signed(op_b) >>> op_a[4:0];
         ALU_AND:  result = op_a & op_b;
         ALU_OR:   result = op_a | op_b;
         ALU_XOR:  result = op_a ^ op_b;
         ALU_NOR:  result = ~(op_a | op_b);
         // signed compare, for slt and slti
         ALU_SLT:  result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         ALU_LUI:  result = {op_b[15:0], 16'h0000};
         default:  result = '0;
      endcase
   end

endmodule

// File: hdl/mips_exec.sv
`timescale 1ns/100ps
// ####################
// execute engine top level
// queue, issue control, decode, regfile, alu
// write-back output register
// ####################
module mips_exec import mips_pkg::*; #(
   parameter int IQ_DEPTH   = IQ_DEPTH_DEF,
   parameter int WB_CREDITS = WB_CREDITS_DEF
) (
   input  logic        clk,
   input  logic        rst_b,
   input  inst_pkt_t   inst_in,
   output logic        inst_credit,
   output wb_pkt_t     wb_out,
   input  logic        wb_credit,
   output logic        halted,
   output halt_cause_e halt_cause
);

   word_t     head;
   logic      not_empty;
   logic      pop;
   logic      has_credit;
   logic      issue_wb;
   dec_ctrl_t ctrl;
   reg_idx_t  rs;
   reg_idx_t  rt;
   word_t     rs_data;
   word_t     rt_data;
   word_t     alu_b;
   word_t     alu_result;

   inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_queue (
      .clk(clk), .rst_b(rst_b), .inst_in(inst_in), .pop(pop),
      .head(head), .not_empty(not_empty), .inst_credit(inst_credit)
   );

   issue_fsm u_issue (
      .clk(clk), .rst_b(rst_b), .not_empty(not_empty), .has_credit(has_credit),
      .ctrl(ctrl), .pop(pop), .issue_wb(issue_wb), .halted(halted),
      .halt_cause(halt_cause)
   );

   // one credit per packet, taken at the issue edge
   credit_counter #(.WB_CREDITS(WB_CREDITS)) u_credit (
      .clk(clk), .rst_b(rst_b), .spend(issue_wb), .wb_credit(wb_credit),
      .has_credit(has_credit)
   );

   // decode straight off the queue head
   inst_decode u_decode (.inst(head), .ctrl(ctrl), .rs(rs), .rt(rt));

   regfile u_regs (
      .clk(clk), .rst_b(rst_b), .rs(rs), .rt(rt), .we(issue_wb),
      .wr_idx(ctrl.dest), .wr_data(alu_result), .rs_data(rs_data), .rt_data(rt_data)
   );

   // second operand is rt or the extended immediate
   assign alu_b = ctrl.use_imm ? ctrl.imm : rt_data;

   mips_alu u_alu (
      .op(ctrl.alu_op), .op_a(rs_data), .op_b(alu_b), .shamt(head[10:6]),
      .result(alu_result)
   );

   // packet goes out the cycle after issue, same value the regfile took
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_out <= '0;
      end else begin
         wb_out.valid <= issue_wb;
         if (issue_wb) begin
            wb_out.dest <= ctrl.dest;
            wb_out.data <= alu_result;
         end
      end
   end

endmodule

// File: hdl/mips_pkg.sv
// ####################
// shared types for the execute engine
// opcode, funct and alu operation enums
// issue states and halt causes
// stream packets and decoder control
// ####################
package mips_pkg;

   // default sizes, overridden from the top level
   parameter int IQ_DEPTH_DEF   = 4;
   parameter int WB_CREDITS_DEF = 2;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // primary opcodes still handled by the engine
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f
   } opcode_e;

   // function field of SPECIAL instructions
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV,
      ALU_SRAV, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_LUI
   } alu_op_e;

   typedef enum logic {
      ST_RUN,
      ST_HALTED
   } core_state_e;

   typedef enum logic [1:0] {
      HALT_NONE,
      HALT_SYSCALL,
      HALT_RI
   } halt_cause_e;

   // instruction stream beat
   typedef struct packed {
      logic  valid;
      word_t inst;
   } inst_pkt_t;

   // write-back stream beat
   typedef struct packed {
      logic     valid;
      reg_idx_t dest;
      word_t    data;
   } wb_pkt_t;

   // decoder output, imm is already extended
   typedef struct packed {
      alu_op_e  alu_op;
      logic     use_imm;
      word_t    imm;
      reg_idx_t dest;
      logic     writes;
      logic     is_syscall;
      logic     is_ri;
   } dec_ctrl_t;

endpackage

// File: hdl/regfile.sv
`timescale 1ns/100ps
// ####################
// 32x32 register file
// two reads, one write
// ####################
module regfile import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   input  logic     we,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data,
   output word_t    rs_data,
   output word_t    rt_data
);

   word_t regs [32];

   // all registers start at zero
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // $zero is hardwired, whatever was written to it
   assign rs_data = (rs == '0) ? '0 : regs[rs];
   assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// File: mips_exec.f
hdl/mips_pkg.sv
hdl/inst_queue.sv
hdl/issue_fsm.sv
hdl/credit_counter.sv
hdl/inst_decode.sv
hdl/regfile.sv
hdl/mips_alu.sv
hdl/mips_exec.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_mips_exec.sv

// File: tests/tb_checker.sv
`timescale 1ns/100ps
// ####################
// reference model of the register file
// in-order compare of write-backs and halt
// credit bookkeeping on both streams
// ####################
module tb_checker import mips_pkg::*; #(
   parameter int IQ_DEPTH   = IQ_DEPTH_DEF,
   parameter int WB_CREDITS = WB_CREDITS_DEF
) (
   input  logic        clk,
   input  logic        rst_b,
   input  inst_pkt_t   inst_in,
   input  logic        inst_credit,
   input  wb_pkt_t     wb_out,
   input  logic        wb_credit,
   input  logic        halted,
   input  halt_cause_e halt_cause,
   output int          value_errs,
   output int          proto_errs,
   output int          wb_count,
   output int          pending
);

   word_t       mregs [32];
   // {dest, data} in issue order
   logic [36:0] exp_q [$];
   halt_cause_e exp_cause;
   logic        halt_seen;
   int          snd_cred;
   int          wb_cred;
   // credit seen at the last edge, usable by the engine from this one
   logic        cred_d;
   int          sent;
   int          returned;

   task automatic flag_protocol(input string msg);
      proto_errs++;
      $display("protocol error at %0t: %s", $time, msg);
   endtask

   task automatic compare_field(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         value_errs++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   // execute one instruction on the model, from the ISA rules
   task automatic model_step(input word_t w);
      logic [5:0] op;
      logic [5:0] fn;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      reg_idx_t   dest;
      logic [4:0] sh;
      word_t      a;
      word_t      b;
      word_t      simm;
      word_t      zimm;
      word_t      r;
      logic       wr;
      op   = w[31:26];
      fn   = w[5:0];
      rs   = w[25:21];
      rt   = w[20:16];
      rd   = w[15:11];
      sh   = w[10:6];
      a    = mregs[rs];
      b    = mregs[rt];
      simm = {{16{w[15]}}, w[15:0]};
      zimm = {16'h0000, w[15:0]};
      r    = '0;
      dest = rt;
      wr   = 1'b1;
      case (op)
         OP_SPECIAL: begin
            dest = rd;
            case (fn)
               FN_SLL:  r = b << sh;
               FN_SRL:  r = b >> sh;
               FN_SRA:  r = $signed(b) >>> sh;
               FN_SLLV: r = b << a[4:0];
               FN_SRLV: r = b >> a[4:0];
               FN_SRAV: r = $signed(b) >>> a[4:0];
               FN_ADDU: r = a + b;
               FN_SUBU: r = a - b;
               FN_AND:  r = a & b;
               FN_OR:   r = a | b;
               FN_XOR:  r = a ^ b;
               FN_NOR:  r = ~(a | b);
               FN_SLT:  r = {31'b0, $signed(a) < $signed(b)};
               FN_SYSCALL: begin
                  wr        = 1'b0;
                  exp_cause = HALT_SYSCALL;
               end
               default: begin
                  wr        = 1'b0;
                  exp_cause = HALT_RI;
               end
            endcase
         end
         OP_ADDIU: r = a + simm;
         OP_SLTI:  r = {31'b0, $signed(a) < $signed(simm)};
         OP_ANDI:  r = a & zimm;
         OP_ORI:   r = a | zimm;
         OP_XORI:  r = a ^ zimm;
         OP_LUI:   r = {w[15:0], 16'h0000};
         default: begin
            wr        = 1'b0;
            exp_cause = HALT_RI;
         end
      endcase
      if (wr) begin
         // $zero keeps its value but the packet still goes out
         if (dest != '0) begin
            mregs[dest] = r;
         end
         exp_q.push_back({dest, r});
      end
   endtask

   // sample at the rising edge, inputs settled half a cycle earlier
   always @(posedge clk) begin : sample
      logic [36:0] exp_pkt;
      if (!rst_b) begin
         if (exp_q.size() != 0) begin
            flag_protocol("write-backs still missing when reset came");
         end
         if (halted || wb_out.valid || inst_credit || halt_cause != HALT_NONE) begin
            flag_protocol("outputs not cleared during reset");
         end
         for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
         end
         exp_q.delete();
         exp_cause = HALT_NONE;
         halt_seen = 1'b0;
         snd_cred  = IQ_DEPTH;
         wb_cred   = WB_CREDITS;
         cred_d    = 1'b0;
         sent      = 0;
         returned  = 0;
      end else begin
         // input side, credit back before a new send
         if (inst_credit) begin
            returned++;
            snd_cred++;
            if (returned > sent) begin
               flag_protocol("more input credits returned than instructions sent");
            end
         end
         if (inst_in.valid) begin
            if (snd_cred == 0) begin
               flag_protocol("instruction sent without an input credit");
            end
            snd_cred--;
            sent++;
            model_step(inst_in.inst);
         end
         // output side, packet spent its credit at the issue edge
         if (wb_out.valid) begin
            wb_count++;
            if (wb_cred == 0) begin
               flag_protocol("write-back sent while the engine held no credit");
            end else begin
               wb_cred--;
            end
            if (exp_q.size() == 0) begin
               flag_protocol("write-back with no instruction left to account for it");
            end else begin
               exp_pkt = exp_q.pop_front();
               compare_field("wb_out.dest", word_t'(exp_pkt[36:32]), word_t'(wb_out.dest));
               compare_field("wb_out.data", exp_pkt[31:0], wb_out.data);
            end
         end
         // a credit taken at the issue edge only counts for the next issue
         if (cred_d) begin
            wb_cred++;
         end
         cred_d = wb_credit;
         // halt cause checked once, on the rise
         if (halted && !halt_seen) begin
            halt_seen = 1'b1;
            if (exp_cause == HALT_NONE) begin
               flag_protocol("engine halted without a halting instruction");
            end else begin
               compare_field("halt_cause", word_t'(exp_cause), word_t'(halt_cause));
            end
         end
      end
      pending = exp_q.size();
   end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps
// ####################
// testbench clock, 40 ns period
// active-low reset, 3 cycles per request
// ####################
module tb_clock (
   input  logic rst_req,
   output logic clk,
   output logic rst_b
);

   // negedges left before release
   logic [2:0] hold;

   initial begin
      clk   = 1'b0;
      rst_b = 1'b0;
      // power-up reset counts down like a requested one
      hold  = 3'd3;
   end

   always #20 clk = ~clk;

   // reset changes on the falling edge, away from the DUT edge
   always @(negedge clk) begin
      if (rst_req) begin
         rst_b <= 1'b0;
         hold  <= 3'd3;
      end else if (hold == 3'd1) begin
         rst_b <= 1'b1;
         hold  <= 3'd0;
      end else if (hold != 3'd0) begin
         hold <= hold - 1'b1;
      end
   end

endmodule

// File: tests/tb_mips_exec.sv
`timescale 1ns/100ps
// ####################
// testbench top for the execute engine
// lfsr stimulus, input and output credits
// two phases ending in SYSCALL and RI, timeout
// ####################
module tb_mips_exec import mips_pkg::*; ();

   localparam int IQ_DEPTH   = 4;
   localparam int WB_CREDITS = 2;
   localparam int N_PHASE1   = 200;
   localparam int N_PHASE2   = 20;
   // each phase adds one halting instruction
   localparam int MAX_CYCLES = 8 * (N_PHASE1 + N_PHASE2 + 2) + 100;
   localparam word_t SYSCALL_WORD = {OP_SPECIAL, 20'h00000, FN_SYSCALL};

   logic        clk;
   logic        rst_b;
   logic        rst_req;
   inst_pkt_t   inst_in;
   logic        inst_credit;
   wb_pkt_t     wb_out;
   logic        wb_credit;
   logic        halted;
   halt_cause_e halt_cause;

   logic [15:0] lfsr;
   int          send_cred;
   int          cycles;
   // cycles left before each owed write-back credit
   int          ret_q [$];
   int          value_errs;
   int          proto_errs;
   int          wb_count;
   int          pending;

   tb_clock u_clock (.rst_req(rst_req), .clk(clk), .rst_b(rst_b));

   mips_exec #(.IQ_DEPTH(IQ_DEPTH), .WB_CREDITS(WB_CREDITS)) i_dut (
      .clk(clk), .rst_b(rst_b), .inst_in(inst_in), .inst_credit(inst_credit),
      .wb_out(wb_out), .wb_credit(wb_credit), .halted(halted), .halt_cause(halt_cause)
   );

   tb_checker #(.IQ_DEPTH(IQ_DEPTH), .WB_CREDITS(WB_CREDITS)) u_checker (
      .clk(clk), .rst_b(rst_b), .inst_in(inst_in), .inst_credit(inst_credit),
      .wb_out(wb_out), .wb_credit(wb_credit), .halted(halted), .halt_cause(halt_cause),
      .value_errs(value_errs), .proto_errs(proto_errs), .wb_count(wb_count),
      .pending(pending)
   );

   // galois lfsr, x^16+x^14+x^13+x^11+1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      end
      return v;
   endfunction

   // random kept instruction, registers 0 to 7
   function automatic word_t make_inst();
      logic [4:0] sel;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] sh;
      logic [15:0] imm;
      logic [5:0] code;
      word_t      w;
      sel  = 5'(rand_bits(5) % 19);
      rs   = reg_idx_t'(rand_bits(3));
      rt   = reg_idx_t'(rand_bits(3));
      rd   = reg_idx_t'(rand_bits(3));
      sh   = 5'(rand_bits(5));
      imm  = 16'(rand_bits(16));
      case (sel)
         5'd0:    code = FN_ADDU;
         5'd1:    code = FN_SUBU;
         5'd2:    code = FN_AND;
         5'd3:    code = FN_OR;
         5'd4:    code = FN_XOR;
         5'd5:    code = FN_NOR;
         5'd6:    code = FN_SLT;
         5'd7:    code = FN_SLL;
         5'd8:    code = FN_SRL;
         5'd9:    code = FN_SRA;
         5'd10:   code = FN_SLLV;
         5'd11:   code = FN_SRLV;
         5'd12:   code = FN_SRAV;
         5'd13:   code = OP_ADDIU;
         5'd14:   code = OP_SLTI;
         5'd15:   code = OP_ANDI;
         5'd16:   code = OP_ORI;
         5'd17:   code = OP_XORI;
         default: code = OP_LUI;
      endcase
      if (sel < 5'd13) begin
         w = {OP_SPECIAL, rs, rt, rd, sh, code};
      end else begin
         w = {code, rs, rt, imm};
      end
      return w;
   endfunction

   // one falling edge, credits in both directions, timeout
   task automatic tick();
      @(negedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout after %0d cycles, the engine never finished", cycles);
         $display("test failed");
         $finish;
      end
      inst_in.valid = 1'b0;
      if (inst_credit) begin
         send_cred++;
      end
      // receiver hands each credit back 0 to 3 cycles later
      if (wb_out.valid) begin
         ret_q.push_back(int'(rand_bits(2)));
      end
      wb_credit = 1'b0;
      if (ret_q.size() > 0) begin
         if (ret_q[0] == 0) begin
            void'(ret_q.pop_front());
            wb_credit = 1'b1;
         end else begin
            ret_q[0] = ret_q[0] - 1;
         end
      end
   endtask

   // at most one per cycle, only with a credit in hand
   task automatic send_inst(input word_t w);
      tick();
      while (send_cred == 0) begin
         tick();
      end
      inst_in.inst  = w;
      inst_in.valid = 1'b1;
      send_cred--;
   endtask

   task automatic wait_halt();
      while (halted !== 1'b1) begin
         tick();
      end
      // let late credits settle and stray packets show up
      repeat (8) tick();
   endtask

   task automatic run_phase(input int n, input word_t last);
      for (int i = 0; i < n; i++) begin
         send_inst(make_inst());
      end
      send_inst(last);
      wait_halt();
   endtask

   initial begin
      word_t ri_word;
      inst_in   = '0;
      wb_credit = 1'b0;
      rst_req   = 1'b0;
      lfsr      = 16'd64746;
      send_cred = IQ_DEPTH;
      cycles    = 0;
      while (rst_b !== 1'b1) begin
         tick();
      end
      run_phase(N_PHASE1, SYSCALL_WORD);
      // second reset, clock module holds it 3 cycles
      rst_req <= 1'b1;
      tick();
      rst_req <= 1'b0;
      while (rst_b !== 1'b0) begin
         tick();
      end
      while (rst_b !== 1'b1) begin
         tick();
      end
      ret_q.delete();
      send_cred = IQ_DEPTH;
      // opcode 0x02 was a jump, now reserved
      ri_word = {6'h02, 26'(rand_bits(26))};
      run_phase(N_PHASE2, ri_word);
      if (pending != 0) begin
         $display("write-backs were still expected when the run ended");
      end
      $display("run done: %0d write-backs, %0d value errors, %0d protocol errors, %0d missing",
               wb_count, value_errs, proto_errs, pending);
      if (value_errs == 0 && proto_errs == 0 && pending == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
